// File: testbench/calc_trace.txt
# columns: scan code, then expected disp after the key (hex, digit codes d3 d2 d1 d0)
# code B is the minus sign and code F a blank digit
5A FFFF
79 FFFF
46 FFF9
46 FF99
5A FF99
26 FF99
79 FF99
46 FFF9
46 FF99
5A F198
26 FFF3
1C FFF3
5A FFF3
7B FFF3
25 FFF4
2E FF45
5A FB42
79 FB42
16 FFF1
1E FF12
26 FF23
5A FF23
7C FF23
45 FFF0
25 FFF4
5A FF92
7B FF92
5A FF92
46 FFF9
1E FF92
5A FFF0
46 FFF9
46 FF99
5A FF99
7C FF99
46 FFF9
46 FF99
5A 9801
79 9801

// File: calculator.f
+incdir+include
src/calc_pkg.sv
src/bcd_formatter.sv
src/key_decoder.sv
src/calc_fsm.sv
src/seg_scanner.sv
src/calculator_top.sv
testbench/tb_calculator.sv

// File: Bender.yml
package:
  name: calculator

sources:
  - include_dirs:
      - include
    files:
      - src/calc_pkg.sv
      - src/bcd_formatter.sv
      - src/key_decoder.sv
      - src/calc_fsm.sv
      - src/seg_scanner.sv
      - src/calculator_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_calculator.sv

// File: testbench/tb_calculator.sv
`default_nettype none

`include "calc_consts.svh"

module tb_calculator import calc_pkg::*; ();

    localparam int ACK_WAIT = 10;  // cycles allowed for each handshake phase.

    logic        clk = 1'b0;
    logic        rst_n;
    logic        key_req;
    logic [7:0]  key_scan;
    logic        key_ack;
    disp_t       disp;
    logic [6:0]  seg;
    logic [3:0]  an;

    logic [7:0]  trace_scan[$];
    logic [15:0] trace_disp[$];
    int          mismatches = 0;
    int          failures = 0;
    int          cycles = 0;
    int          cycle_limit = 100;
    int          scan_checks = 0;
    integer      seed = 32'hd106cc1a;
    logic [3:0]  an_prev = 4'b0000;

    calculator_top i_calculator_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_req  (key_req),
        .key_scan (key_scan),
        .key_ack  (key_ack),
        .disp     (disp),
        .seg      (seg),
        .an       (an)
    );

    always #50 clk = ~clk;

    // segment order is gfedcba with segment a in bit 0.
    function automatic logic [6:0] seg_pattern(input logic [3:0] code);
        case (code)
            4'd0:       seg_pattern = 7'b0111111;
            4'd1:       seg_pattern = 7'b0000110;
            4'd2:       seg_pattern = 7'b1011011;
            4'd3:       seg_pattern = 7'b1001111;
            4'd4:       seg_pattern = 7'b1100110;
            4'd5:       seg_pattern = 7'b1101101;
            4'd6:       seg_pattern = 7'b1111101;
            4'd7:       seg_pattern = 7'b0000111;
            4'd8:       seg_pattern = 7'b1111111;
            4'd9:       seg_pattern = 7'b1101111;
            `DIG_MINUS: seg_pattern = 7'b1000000;
            default:    seg_pattern = 7'b0000000;
        endcase
    endfunction

    // runs one full four-phase handshake and then checks the display.
    task automatic send_key(input logic [7:0] scan, input logic [15:0] expected);
        int   waits;
        logic got_ack;
        @(posedge clk);
        key_scan <= scan;
        key_req  <= 1'b1;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!key_ack && waits < ACK_WAIT);
        got_ack = key_ack;
        @(posedge clk);
        key_req <= 1'b0;
        if (!got_ack) begin
            $display("handshake failure: no ack came for scan code %h", scan);
            failures++;
        end else begin
            waits = 0;
            do begin
                @(negedge clk);
                waits++;
            end while (key_ack && waits < ACK_WAIT);
            if (key_ack) begin
                $display("handshake failure: ack stayed high after req fell, scan code %h", scan);
                failures++;
            end else if (disp !== expected) begin
                $display("MISMATCH disp expected %h actual %h (scan code %h)",
                         expected, disp, scan);
                mismatches++;
            end
        end
    endtask

    // checks seg whenever the scanner moves to another digit.
    always @(negedge clk) begin
        logic [3:0] sel;
        logic       onehot;
        if (rst_n && an !== an_prev) begin
            onehot = 1'b1;
            case (an)
                4'b0001: sel = disp.d0;
                4'b0010: sel = disp.d1;
                4'b0100: sel = disp.d2;
                4'b1000: sel = disp.d3;
                default: begin
                    sel    = 4'h0;
                    onehot = 1'b0;
                end
            endcase
            if (an_prev != 4'b0000 && an !== {an_prev[2:0], an_prev[3]}) begin
                $display("scan order broken: an went from %b to %b", an_prev, an);
                failures++;
            end
            if (!onehot) begin
                $display("an is not one-hot: %b", an);
                failures++;
            end else if (seg !== seg_pattern(sel)) begin
                $display("MISMATCH seg expected %h actual %h (an %h)", seg_pattern(sel), seg, an);
                mismatches++;
            end
            scan_checks++;
            an_prev = an;
        end
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the trace did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int               fd;
        int               n;
        int               gap;
        logic [8*120-1:0] line;
        logic [7:0]       scan;
        logic [15:0]      expected;
        rst_n    = 1'b0;
        key_req  = 1'b0;
        key_scan = 8'h00;
        fd = $fopen("testbench/calc_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file testbench/calc_trace.txt");
            $display("TESTS FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h", scan, expected);  // comment lines give 0.
                    if (n == 2) begin
                        trace_scan.push_back(scan);
                        trace_disp.push_back(expected);
                    end
                end
            end
            $fclose(fd);
            cycle_limit = 20 * trace_scan.size() + 100;

            repeat (4) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            if (disp !== 16'hFFFF) begin
                $display("MISMATCH disp expected %h actual %h after reset", 16'hFFFF, disp);
                mismatches++;
            end
            if (key_ack !== 1'b0) begin
                $display("MISMATCH key_ack expected %h actual %h after reset", 1'b0, key_ack);
                mismatches++;
            end
            if (an !== 4'b0001) begin
                $display("MISMATCH an expected %h actual %h after reset", 4'b0001, an);
                mismatches++;
            end

            foreach (trace_scan[i]) begin
                send_key(trace_scan[i], trace_disp[i]);
                gap = {$random(seed)} % 4;
                repeat (gap) @(posedge clk);
            end

            if (trace_scan.size() == 0) begin
                $display("the trace file holds no key lines");
                failures++;
            end
            if (scan_checks == 0) begin
                $display("the display scan never moved to another digit");
                failures++;
            end
            $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
            if (mismatches + failures == 0)
                $display("TESTS PASSED");
            else
                $display("TESTS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src/calculator_top.sv
`default_nettype none

module calculator_top import calc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_req,
    input  logic [7:0] key_scan,
    output logic       key_ack,
    output disp_t      disp,
    output logic [6:0] seg,
    output logic [3:0] an
);

    logic       key_valid;
    key_event_t key;

    key_decoder i_key_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_req   (key_req),
        .key_scan  (key_scan),
        .key_ack   (key_ack),
        .key_valid (key_valid),
        .key       (key)
    );

    calc_fsm i_calc_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key       (key),
        .disp      (disp)
    );

    seg_scanner i_seg_scanner (
        .clk   (clk),
        .rst_n (rst_n),
        .disp  (disp),
        .seg   (seg),
        .an    (an)
    );

endmodule

`default_nettype wire

// File: src/seg_scanner.sv
`default_nettype none

`include "calc_consts.svh"

module seg_scanner import calc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  disp_t      disp,
    output logic [6:0] seg,
    output logic [3:0] an
);

    localparam int DIV_W = $clog2(`SCAN_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       idx;
    logic [3:0]       code;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            idx     <= 2'd0;
        end else if (div_cnt == DIV_W'(`SCAN_DIV - 1)) begin
            div_cnt <= '0;
            idx     <= idx + 2'd1;  // wraps from d3 back to d0.
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign an = 4'b0001 << idx;

    always_comb begin
        case (idx)
            2'd0:    code = disp.d0;
            2'd1:    code = disp.d1;
            2'd2:    code = disp.d2;
            default: code = disp.d3;
        endcase
    end

    // segments are gfedcba with segment a in bit 0.
    always_comb begin
        case (code)
            4'd0:       seg = 7'h3F;
            4'd1:       seg = 7'h06;
            4'd2:       seg = 7'h5B;
            4'd3:       seg = 7'h4F;
            4'd4:       seg = 7'h66;
            4'd5:       seg = 7'h6D;
            4'd6:       seg = 7'h7D;
            4'd7:       seg = 7'h07;
            4'd8:       seg = 7'h7F;
            4'd9:       seg = 7'h6F;
            `DIG_MINUS: seg = 7'h40;
            default:    seg = 7'h00;  // blank and unused codes stay dark.
        endcase
    end

endmodule

`default_nettype wire

// File: src/calc_fsm.sv
`default_nettype none

`include "calc_consts.svh"

module calc_fsm import calc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_valid,
    input  key_event_t key,
    output disp_t      disp
);

    typedef enum logic [1:0] {
        ENTER_A,
        WAIT_OP,
        ENTER_B,
        SHOW
    } state_t;

    state_t             state, state_nxt;
    logic               a_typed, a_typed_nxt;
    logic               b_typed, b_typed_nxt;
    logic [6:0]         a, a_nxt;
    logic [6:0]         b, b_nxt;
    key_kind_t          op, op_nxt;
    logic signed [14:0] result, result_nxt;
    logic signed [14:0] sa, sb;
    logic signed [14:0] fmt_value;
    disp_t              fmt_digits;
    logic               disp_load;
    logic               is_digit, is_op, is_enter;

    assign is_digit = key_valid && key.kind == KEY_DIGIT;
    assign is_enter = key_valid && key.kind == KEY_ENTER;
    assign is_op    = key_valid && (key.kind == KEY_ADD || key.kind == KEY_SUB ||
                                    key.kind == KEY_MUL);

    assign sa = $signed({8'd0, a});
    assign sb = $signed({8'd0, b});

    // the same formatter renders operands while typing and the final result.
    bcd_formatter i_bcd_formatter (
        .value  (fmt_value),
        .digits (fmt_digits)
    );

    always_comb begin
        state_nxt   = state;
        a_typed_nxt = a_typed;
        b_typed_nxt = b_typed;
        a_nxt       = a;
        b_nxt       = b;
        op_nxt      = op;
        result_nxt  = result;
        fmt_value   = '0;
        disp_load   = 1'b0;
        case (state)
            ENTER_A: begin
                if (is_digit) begin
                    // a third digit pushes the oldest one out.
                    a_nxt       = a_typed ? (a % 7'd10) * 7'd10 + {3'd0, key.value}
                                          : {3'd0, key.value};
                    a_typed_nxt = 1'b1;
                    fmt_value   = $signed({8'd0, a_nxt});
                    disp_load   = 1'b1;
                end else if (is_enter && a_typed) begin
                    state_nxt = WAIT_OP;
                end
            end
            WAIT_OP: begin
                if (is_op) begin
                    op_nxt      = key.kind;
                    b_nxt       = 7'd0;
                    b_typed_nxt = 1'b0;
                    state_nxt   = ENTER_B;
                end
            end
            ENTER_B: begin
                if (is_digit) begin
                    b_nxt       = b_typed ? (b % 7'd10) * 7'd10 + {3'd0, key.value}
                                          : {3'd0, key.value};
                    b_typed_nxt = 1'b1;
                    fmt_value   = $signed({8'd0, b_nxt});
                    disp_load   = 1'b1;
                end else if (is_enter && b_typed) begin
                    case (op)
                        KEY_ADD: result_nxt = sa + sb;
                        KEY_SUB: result_nxt = sa - sb;
                        default: result_nxt = sa * sb;
                    endcase
                    fmt_value = result_nxt;
                    disp_load = 1'b1;
                    state_nxt = SHOW;
                end
            end
            SHOW: begin
                if (is_digit) begin
                    a_nxt       = {3'd0, key.value};
                    a_typed_nxt = 1'b1;
                    b_nxt       = 7'd0;
                    b_typed_nxt = 1'b0;
                    fmt_value   = $signed({11'd0, key.value});
                    disp_load   = 1'b1;
                    state_nxt   = ENTER_A;
                end else if (is_op && result >= 0 && result <= 15'sd99) begin
                    a_nxt       = result[6:0];  // the display already shows this value.
                    a_typed_nxt = 1'b1;
                    op_nxt      = key.kind;
                    b_nxt       = 7'd0;
                    b_typed_nxt = 1'b0;
                    state_nxt   = ENTER_B;
                end
            end
            default: state_nxt = ENTER_A;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ENTER_A;
            a_typed <= 1'b0;
            b_typed <= 1'b0;
            disp    <= {4{`DIG_BLANK}};
        end else begin
            state   <= state_nxt;
            a_typed <= a_typed_nxt;
            b_typed <= b_typed_nxt;
            if (disp_load)
                disp <= fmt_digits;
        end
    end

    always_ff @(posedge clk) begin
        a      <= a_nxt;
        b      <= b_nxt;
        op     <= op_nxt;
        result <= result_nxt;
    end

endmodule

`default_nettype wire

// File: src/key_decoder.sv
`default_nettype none

`include "calc_consts.svh"

module key_decoder import calc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_req,
    input  logic [7:0] key_scan,
    output logic       key_ack,
    output logic       key_valid,
    output key_event_t key
);

    key_event_t dec;
    logic       known;
    logic       accept;

    assign accept = key_req && !key_ack;  // new request while the previous one is closed.

    always_comb begin
        dec   = '{kind: KEY_DIGIT, value: 4'd0};
        known = 1'b1;
        case (key_scan)
            `SC_0:     dec.value = 4'd0;
            `SC_1:     dec.value = 4'd1;
            `SC_2:     dec.value = 4'd2;
            `SC_3:     dec.value = 4'd3;
            `SC_4:     dec.value = 4'd4;
            `SC_5:     dec.value = 4'd5;
            `SC_6:     dec.value = 4'd6;
            `SC_7:     dec.value = 4'd7;
            `SC_8:     dec.value = 4'd8;
            `SC_9:     dec.value = 4'd9;
            `SC_ADD:   dec.kind  = KEY_ADD;
            `SC_SUB:   dec.kind  = KEY_SUB;
            `SC_MUL:   dec.kind  = KEY_MUL;
            `SC_ENTER: dec.kind  = KEY_ENTER;
            default:   known     = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_ack   <= 1'b0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= accept && known;  // unknown codes still get their ack.
            if (accept)
                key_ack <= 1'b1;
            else if (key_ack && !key_req)
                key_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            key <= dec;
    end

endmodule

`default_nettype wire

// File: src/bcd_formatter.sv
`default_nettype none

`include "calc_consts.svh"

module bcd_formatter import calc_pkg::*; (
    input  logic signed [14:0] value,
    output disp_t              digits
);

    logic       neg;
    logic [13:0] mag;
    logic [3:0] thou, hund, tens, ones;

    assign neg = value[14];
    assign mag = neg ? 14'(-value) : value[13:0];  // at most 9801 in practice.

    assign thou = 4'(mag / 14'd1000);
    assign hund = 4'((mag / 14'd100) % 14'd10);
    assign tens = 4'((mag / 14'd10) % 14'd10);
    assign ones = 4'(mag % 14'd10);

    always_comb begin
        digits = '{d3: thou, d2: hund, d1: tens, d0: ones};
        if (mag < 14'd1000)
            digits.d3 = `DIG_BLANK;
        if (mag < 14'd100)
            digits.d2 = `DIG_BLANK;
        if (mag < 14'd10)
            digits.d1 = `DIG_BLANK;

        // the sign goes just left of the leading digit.
        // Negative results never reach 100, so d3 is only a fallback.
        if (neg) begin
            if (mag < 14'd10)
                digits.d1 = `DIG_MINUS;
            else if (mag < 14'd100)
                digits.d2 = `DIG_MINUS;
            else
                digits.d3 = `DIG_MINUS;
        end
    end

endmodule

`default_nettype wire

// File: src/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // class of a decoded key. The three operators double as the stored operation.
    typedef enum logic [2:0] {
        KEY_DIGIT,
        KEY_ADD,
        KEY_SUB,
        KEY_MUL,
        KEY_ENTER
    } key_kind_t;

    typedef struct packed {
        key_kind_t  kind;
        logic [3:0] value;  // digit 0 to 9, only meaningful for KEY_DIGIT.
    } key_event_t;

    // d3 is the leftmost display position.
    typedef struct packed {
        logic [3:0] d3;
        logic [3:0] d2;
        logic [3:0] d1;
        logic [3:0] d0;
    } disp_t;

endpackage

`default_nettype wire

// File: include/calc_consts.svh
`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

// keys send their PS/2 set 2 make codes.
`define SC_0     8'h45
`define SC_1     8'h16
`define SC_2     8'h1E
`define SC_3     8'h26
`define SC_4     8'h25
`define SC_5     8'h2E
`define SC_6     8'h36
`define SC_7     8'h3D
`define SC_8     8'h3E
`define SC_9     8'h46
`define SC_ADD   8'h79
`define SC_SUB   8'h7B
`define SC_MUL   8'h7C
`define SC_ENTER 8'h5A

`define DIG_MINUS 4'd11
`define DIG_BLANK 4'd15

`define SCAN_DIV 4

`endif
